//--- design/muldiv_pkg.sv
package muldiv_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN   = 32;
  // Partial register keeps one extra sign bit
  localparam int PART_W = XLEN + 1;
  // Room for the Booth double plus sign
  localparam int ADD_W  = 35;
  localparam int OP_W   = 3;

  // Operation codes follow funct3
  // Bit 2 selects divide, bit 1 selects remainder, bit 0 unsigned for divides
  localparam logic [OP_W-1:0] OP_MUL    = 3'd0;
  localparam logic [OP_W-1:0] OP_MULH   = 3'd1;
  localparam logic [OP_W-1:0] OP_MULHSU = 3'd2;
  localparam logic [OP_W-1:0] OP_MULHU  = 3'd3;
  localparam logic [OP_W-1:0] OP_DIV    = 3'd4;
  localparam logic [OP_W-1:0] OP_DIVU   = 3'd5;
  localparam logic [OP_W-1:0] OP_REM    = 3'd6;
  localparam logic [OP_W-1:0] OP_REMU   = 3'd7;

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////
  localparam int ST_W = 3;

  localparam logic [ST_W-1:0] ST_IDLE      = 3'd0;
  localparam logic [ST_W-1:0] ST_EXEC      = 3'd1;
  // Divide only, remainder sign check and the two fix-up cycles
  localparam logic [ST_W-1:0] ST_REMD_CHCK = 3'd2;
  localparam logic [ST_W-1:0] ST_QUOT_CORR = 3'd3;
  localparam logic [ST_W-1:0] ST_REMD_CORR = 3'd4;

  localparam int CNT_W = 6;

  // Final execute count, the idle cycle already did step 0
  localparam logic [CNT_W-1:0] MUL_STEPS = 6'd16;
  localparam logic [CNT_W-1:0] DIV_STEPS = 6'd32;

  ////////////////////////////////////////////////////////////
  // Shared adder result, seen two ways
  ////////////////////////////////////////////////////////////
  typedef union packed {
    // Multiply: next high partial product and the two bits shifted out
    struct packed {
      logic [PART_W-1:0] prdt_hi;
      logic [1:0]        sft_out;
    } mul_view;
    // Divide: 34-bit result, sign above the 33-bit remainder
    struct packed {
      logic              pad;
      logic              sign;
      logic [PART_W-1:0] remd;
    } div_view;
  } adder_res_t;

endpackage

//--- design/muldiv_ctrl.sv
`timescale 1ns/1ps

module muldiv_ctrl
  import muldiv_pkg::*;
(
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_valid,
  input  logic [OP_W-1:0] i_op,
  input  logic            i_special,
  input  logic            i_need_corr,
  input  logic            i_o_ready,
  output logic            o_ready,
  output logic            o_valid,
  output logic            o_cycle_0th,
  output logic            o_exec,
  output logic            o_last,
  output logic            o_check,
  output logic            o_quot_corr,
  output logic            o_remd_corr
);

  logic [ST_W-1:0]  state;
  logic [ST_W-1:0]  state_nxt;
  logic [CNT_W-1:0] exec_cnt;
  logic [CNT_W-1:0] last_cnt;
  logic             is_div;
  logic             st_idle;
  logic             start;

  assign is_div  = i_op[2];
  assign st_idle = (state == ST_IDLE);

  // Phase strobes
  assign o_exec      = (state == ST_EXEC);
  assign o_check     = (state == ST_REMD_CHCK);
  assign o_quot_corr = (state == ST_QUOT_CORR);
  assign o_remd_corr = (state == ST_REMD_CORR);

  // Special divides finish in idle, no step cycle
  assign start       = st_idle & i_valid & ~i_special;
  assign o_cycle_0th = start;

  assign last_cnt = is_div ? DIV_STEPS : MUL_STEPS;
  assign o_last   = o_exec & (exec_cnt == last_cnt);

  ////////////////////////////////////////////////////////////
  // Write-back handshake
  ////////////////////////////////////////////////////////////
  assign o_valid = (st_idle & i_valid & i_special)
                 | (o_last & ~is_div)
                 | (o_check & ~i_need_corr)
                 | o_remd_corr;
  // Issue is taken on the same edge as the write-back
  assign o_ready = o_valid & i_o_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_EXEC;
        end
      end
      ST_EXEC: begin
        // Multiply holds here until the sink takes it
        if (o_last && is_div) begin
          state_nxt = ST_REMD_CHCK;
        end else if (o_last && o_ready) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (i_need_corr) begin
          state_nxt = ST_QUOT_CORR;
        end else if (o_ready) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_QUOT_CORR: state_nxt = ST_REMD_CORR;
      ST_REMD_CORR: begin
        if (o_ready) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Starts at 1 since the idle cycle counts as step 0
  always_ff @(posedge clk) begin
    if (i_reset) begin
      exec_cnt <= '0;
    end else if (start) begin
      exec_cnt <= CNT_W'(1);
    end else if (o_exec && !o_last) begin
      exec_cnt <= exec_cnt + CNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_cnt_range: assert property (@(posedge clk) disable iff (i_reset)
    exec_cnt <= DIV_STEPS);

  // Source keeps the request up until it is consumed
  a_valid_held: assert property (@(posedge clk) disable iff (i_reset)
    o_valid |-> i_valid);

endmodule

//--- design/booth_mul_step.sv
`timescale 1ns/1ps

module booth_mul_step
  import muldiv_pkg::*;
(
  input  logic [OP_W-1:0]   i_op,
  input  logic [XLEN-1:0]   i_rs1,
  input  logic [XLEN-1:0]   i_rs2,
  input  logic              i_cycle_0th,
  input  logic              i_last,
  input  logic [PART_W-1:0] i_part_hi,
  input  logic [PART_W-1:0] i_part_lo,
  input  logic              i_part_sft1,
  input  adder_res_t        i_add_res,
  output logic [ADD_W-1:0]  o_op1,
  output logic [ADD_W-1:0]  o_op2,
  output logic              o_sub,
  output logic [PART_W-1:0] o_hi_nxt,
  output logic [PART_W-1:0] o_lo_nxt,
  output logic              o_sft1_nxt,
  output logic [XLEN-1:0]   o_res
);

  logic       rs1_sign;
  logic       rs2_sign;
  logic [2:0] booth_code;
  logic       sel_zero;
  logic       sel_two;
  logic       sel_one;

  // MULHU treats both as unsigned, MULHSU only rs2
  assign rs1_sign = (i_op == OP_MULHU) ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign = (i_op == OP_MULHU || i_op == OP_MULHSU) ? 1'b0 : i_rs2[XLEN-1];

  ////////////////////////////////////////////////////////////
  // Radix-4 recoding
  ////////////////////////////////////////////////////////////
  // Step 0 looks at rs1 directly, last step uses the extended sign bit
  assign booth_code = i_cycle_0th ? {i_rs1[1:0], 1'b0}
                    : i_last      ? {rs1_sign, i_part_lo[0], i_part_sft1}
                    :               {i_part_lo[1:0], i_part_sft1};

  // 000 and 111 add nothing, 011 and 100 take the double
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);
  assign sel_one  = ~sel_zero & ~sel_two;
  // Upper code bit set means negative multiple
  assign o_sub    = booth_code[2];

  assign o_op1 = i_cycle_0th ? '0 : {i_part_hi[PART_W-1], i_part_hi[PART_W-1], i_part_hi};
  assign o_op2 = ({ADD_W{sel_one}} & {rs2_sign, rs2_sign, rs2_sign, i_rs2})
               | ({ADD_W{sel_two}} & {rs2_sign, rs2_sign, i_rs2, 1'b0});

  ////////////////////////////////////////////////////////////
  // Partial product update
  ////////////////////////////////////////////////////////////
  assign o_hi_nxt   = i_add_res.mul_view.prdt_hi;
  // Low bits of the sum shift into the top of the multiplier register
  assign o_lo_nxt   = {i_add_res.mul_view.sft_out,
                       i_cycle_0th ? {rs1_sign, i_rs1[XLEN-1:2]} : i_part_lo[PART_W-1:2]};
  assign o_sft1_nxt = i_cycle_0th ? i_rs1[1] : i_part_lo[1];

  // MUL reads the low word already shifted out
  // High variants take the last sum straight from the adder
  assign o_res = (i_op == OP_MUL) ? i_part_lo[PART_W-1:1]
               : {i_add_res.mul_view.prdt_hi[XLEN-3:0], i_add_res.mul_view.sft_out};

endmodule

//--- design/nonrest_div_step.sv
`timescale 1ns/1ps

module nonrest_div_step
  import muldiv_pkg::*;
(
  input  logic [OP_W-1:0]   i_op,
  input  logic [XLEN-1:0]   i_rs1,
  input  logic [XLEN-1:0]   i_rs2,
  input  logic              i_cycle_0th,
  input  logic              i_exec,
  input  logic              i_last,
  input  logic              i_check,
  input  logic              i_quot_corr,
  input  logic              i_remd_corr,
  input  logic [PART_W-1:0] i_part_hi,
  input  logic [PART_W-1:0] i_part_lo,
  input  logic              i_remd_sft1,
  input  adder_res_t        i_add_res,
  output logic [ADD_W-1:0]  o_op1,
  output logic [ADD_W-1:0]  o_op2,
  output logic              o_sub,
  output logic              o_hi_ena,
  output logic [PART_W-1:0] o_hi_nxt,
  output logic              o_lo_ena,
  output logic [PART_W-1:0] o_lo_nxt,
  output logic              o_remd_sft1_nxt,
  output logic              o_need_corr,
  output logic              o_special,
  output logic [XLEN-1:0]   o_res
);

  logic              is_div;
  logic              is_quot;
  logic              rs1_sign;
  logic              rs2_sign;
  logic [PART_W:0]   divisor;
  logic              quot_0th;
  logic [PART_W:0]   add_sum;
  logic [PART_W-1:0] quot_in;
  logic              cur_quot;
  logic              remd_fix_up;
  logic [PART_W:0]   req_op1;
  logic [PART_W:0]   req_op2;
  logic              div_by_0;
  logic              div_ovf;
  logic [XLEN-1:0]   special_res;
  logic [XLEN-1:0]   div_remd;

  assign is_div   = i_op[2];
  assign is_quot  = ~i_op[1];
  // Bit 0 marks the unsigned forms
  assign rs1_sign = ~i_op[0] & i_rs1[XLEN-1];
  assign rs2_sign = ~i_op[0] & i_rs2[XLEN-1];
  assign divisor  = {rs2_sign, rs2_sign, i_rs2};

  assign add_sum  = {i_add_res.div_view.sign, i_add_res.div_view.remd};

  ////////////////////////////////////////////////////////////
  // One step per cycle
  ////////////////////////////////////////////////////////////
  // First digit from sign of dividend against divisor
  assign quot_0th = ~(rs1_sign ^ rs2_sign);
  assign quot_in  = i_cycle_0th ? {i_rs1, quot_0th} : i_part_lo;
  // Digit is 1 when the new remainder keeps the divisor sign
  assign cur_quot = ~(add_sum[PART_W] ^ rs2_sign);

  // Remainder sign mismatch decides which way the fix-up goes
  assign remd_fix_up = i_part_hi[PART_W-1] ^ rs2_sign;

  always_comb begin
    req_op1 = '0;
    req_op2 = '0;
    o_sub   = 1'b0;
    if (i_cycle_0th || i_exec) begin
      // Subtract after a 1 digit, add after a 0 digit
      req_op1 = i_cycle_0th ? {(PART_W+1){rs1_sign}} : {i_remd_sft1, i_part_hi};
      req_op2 = divisor;
      o_sub   = i_cycle_0th ? quot_0th : i_part_lo[0];
    end else if (i_check) begin
      // Zero sum here means remainder equals minus divisor
      req_op1 = {i_part_hi[PART_W-1], i_part_hi};
      req_op2 = divisor;
    end else if (i_quot_corr) begin
      req_op1 = {i_part_lo[PART_W-1], i_part_lo};
      req_op2 = (PART_W+1)'(1);
      o_sub   = remd_fix_up;
    end else if (i_remd_corr) begin
      req_op1 = {i_part_hi[PART_W-1], i_part_hi};
      req_op2 = divisor;
      o_sub   = ~remd_fix_up;
    end
  end

  assign o_op1 = {1'b0, req_op1};
  assign o_op2 = {1'b0, req_op2};

  // Remainder is left in place once corrected, no reuse downstream
  assign o_hi_ena = is_div & (i_cycle_0th | i_exec);
  assign o_lo_ena = is_div & (i_cycle_0th | i_exec | i_quot_corr);

  // Last step keeps the remainder unshifted and forces the final digit
  assign o_hi_nxt = (i_exec && i_last) ? add_sum[PART_W-1:0]
                  : {add_sum[XLEN-1:0], quot_in[PART_W-1]};
  assign o_lo_nxt = i_quot_corr          ? add_sum[PART_W-1:0]
                  : (i_exec && i_last)   ? {quot_in[XLEN-1:0], 1'b1}
                  :                        {quot_in[XLEN-1:0], cur_quot};
  assign o_remd_sft1_nxt = add_sum[PART_W-1];

  ////////////////////////////////////////////////////////////
  // Correction check
  ////////////////////////////////////////////////////////////
  assign o_need_corr = is_div
                     & (((i_part_hi[PART_W-1] ^ rs1_sign) & (|i_part_hi))
                        | ~(|add_sum)
                        | (i_part_hi == divisor[PART_W-1:0]));

  ////////////////////////////////////////////////////////////
  // Special cases and result
  ////////////////////////////////////////////////////////////
  assign div_by_0  = ~(|i_rs2);
  // Most negative over minus one, signed forms only
  assign div_ovf   = ~i_op[0] & (&i_rs2) & (i_rs1 == {1'b1, {(XLEN-1){1'b0}}});
  assign o_special = is_div & (div_by_0 | div_ovf);

  assign special_res = div_by_0 ? (is_quot ? '1 : i_rs1)
                     :            (is_quot ? {1'b1, {(XLEN-1){1'b0}}} : '0);

  // Corrected remainder comes straight off the adder
  assign div_remd = i_remd_corr ? add_sum[XLEN-1:0] : i_part_hi[XLEN-1:0];

  assign o_res = o_special ? special_res
               : is_quot   ? i_part_lo[XLEN-1:0]
               :             div_remd;

endmodule

//--- design/muldiv_share.sv
`timescale 1ns/1ps

module muldiv_share
  import muldiv_pkg::*;
(
  input  logic              clk,
  input  logic              i_reset,
  input  logic [OP_W-1:0]   i_op,
  input  logic              i_cycle_0th,
  input  logic              i_exec,
  input  logic              i_last,
  input  logic              i_special,
  // Multiply side
  input  logic [ADD_W-1:0]  i_mul_op1,
  input  logic [ADD_W-1:0]  i_mul_op2,
  input  logic              i_mul_sub,
  input  logic [PART_W-1:0] i_mul_hi_nxt,
  input  logic [PART_W-1:0] i_mul_lo_nxt,
  input  logic              i_mul_sft1_nxt,
  input  logic [XLEN-1:0]   i_mul_res,
  // Divide side
  input  logic [ADD_W-1:0]  i_div_op1,
  input  logic [ADD_W-1:0]  i_div_op2,
  input  logic              i_div_sub,
  input  logic              i_div_hi_ena,
  input  logic [PART_W-1:0] i_div_hi_nxt,
  input  logic              i_div_lo_ena,
  input  logic [PART_W-1:0] i_div_lo_nxt,
  input  logic              i_div_remd_sft1_nxt,
  input  logic [XLEN-1:0]   i_div_res,
  output adder_res_t        o_add_res,
  output logic [PART_W-1:0] o_part_hi,
  output logic [PART_W-1:0] o_part_lo,
  output logic              o_part_sft1,
  output logic              o_remd_sft1,
  output logic [XLEN-1:0]   o_data
);

  logic             is_div;
  logic [ADD_W-1:0] op1;
  logic [ADD_W-1:0] op2;
  logic             sub;
  logic             mul_ena;
  logic             hi_ena;
  logic             lo_ena;

  assign is_div = i_op[2];

  ////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////
  assign op1 = is_div ? i_div_op1 : i_mul_op1;
  assign op2 = is_div ? i_div_op2 : i_mul_op2;
  assign sub = is_div ? i_div_sub : i_mul_sub;

  assign o_add_res = sub ? (op1 - op2) : (op1 + op2);

  // Multiply steps in idle and in execute, frozen on its last count
  assign mul_ena = ~is_div & (i_cycle_0th | (i_exec & ~i_last));
  assign hi_ena  = is_div ? i_div_hi_ena : mul_ena;
  assign lo_ena  = is_div ? i_div_lo_ena : mul_ena;

  ////////////////////////////////////////////////////////////
  // Partial registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_part_hi   <= '0;
      o_remd_sft1 <= 1'b0;
    end else if (hi_ena) begin
      o_part_hi   <= is_div ? i_div_hi_nxt : i_mul_hi_nxt;
      // Remainder carry only matters for divides
      o_remd_sft1 <= is_div ? i_div_remd_sft1_nxt : o_remd_sft1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_part_lo   <= '0;
      o_part_sft1 <= 1'b0;
    end else if (lo_ena) begin
      o_part_lo   <= is_div ? i_div_lo_nxt : i_mul_lo_nxt;
      o_part_sft1 <= is_div ? o_part_sft1 : i_mul_sft1_nxt;
    end
  end

  // Write-back word
  assign o_data = is_div ? i_div_res : i_mul_res;

  // Outside step 0 and execute only divide fix-ups may write
  // and those never run on a special case
  a_idle_frozen: assert property (@(posedge clk) disable iff (i_reset)
    ((hi_ena || lo_ena) && !i_cycle_0th && !i_exec) |-> (is_div && !i_special));

endmodule

//--- design/muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top
  import muldiv_pkg::*;
(
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_valid,
  output logic            o_ready,
  input  logic [OP_W-1:0] i_op,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  output logic            o_valid,
  input  logic            i_o_ready,
  output logic [XLEN-1:0] o_data
);

  // Phase strobes
  logic cycle_0th;
  logic exec;
  logic last;
  logic check;
  logic quot_corr;
  logic remd_corr;
  logic special;
  logic need_corr;

  // Multiply request
  logic [ADD_W-1:0]  mul_op1;
  logic [ADD_W-1:0]  mul_op2;
  logic              mul_sub;
  logic [PART_W-1:0] mul_hi_nxt;
  logic [PART_W-1:0] mul_lo_nxt;
  logic              mul_sft1_nxt;
  logic [XLEN-1:0]   mul_res;

  // Divide request
  logic [ADD_W-1:0]  div_op1;
  logic [ADD_W-1:0]  div_op2;
  logic              div_sub;
  logic              div_hi_ena;
  logic [PART_W-1:0] div_hi_nxt;
  logic              div_lo_ena;
  logic [PART_W-1:0] div_lo_nxt;
  logic              div_remd_sft1_nxt;
  logic [XLEN-1:0]   div_res;

  // Shared state
  adder_res_t        add_res;
  logic [PART_W-1:0] part_hi;
  logic [PART_W-1:0] part_lo;
  logic              part_sft1;
  logic              remd_sft1;

  muldiv_ctrl u_ctrl (
    .clk (clk), .i_reset (i_reset),
    .i_valid (i_valid), .i_op (i_op),
    .i_special (special), .i_need_corr (need_corr),
    .i_o_ready (i_o_ready), .o_ready (o_ready), .o_valid (o_valid),
    .o_cycle_0th (cycle_0th), .o_exec (exec), .o_last (last),
    .o_check (check), .o_quot_corr (quot_corr), .o_remd_corr (remd_corr)
  );

  booth_mul_step u_mul (
    .i_op (i_op), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
    .i_cycle_0th (cycle_0th), .i_last (last),
    .i_part_hi (part_hi), .i_part_lo (part_lo), .i_part_sft1 (part_sft1),
    .i_add_res (add_res),
    .o_op1 (mul_op1), .o_op2 (mul_op2), .o_sub (mul_sub),
    .o_hi_nxt (mul_hi_nxt), .o_lo_nxt (mul_lo_nxt), .o_sft1_nxt (mul_sft1_nxt),
    .o_res (mul_res)
  );

  nonrest_div_step u_div (
    .i_op (i_op), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
    .i_cycle_0th (cycle_0th), .i_exec (exec), .i_last (last), .i_check (check),
    .i_quot_corr (quot_corr), .i_remd_corr (remd_corr),
    .i_part_hi (part_hi), .i_part_lo (part_lo), .i_remd_sft1 (remd_sft1),
    .i_add_res (add_res),
    .o_op1 (div_op1), .o_op2 (div_op2), .o_sub (div_sub),
    .o_hi_ena (div_hi_ena), .o_hi_nxt (div_hi_nxt),
    .o_lo_ena (div_lo_ena), .o_lo_nxt (div_lo_nxt),
    .o_remd_sft1_nxt (div_remd_sft1_nxt), .o_need_corr (need_corr),
    .o_special (special), .o_res (div_res)
  );

  muldiv_share u_share (
    .clk (clk), .i_reset (i_reset), .i_op (i_op),
    .i_cycle_0th (cycle_0th), .i_exec (exec), .i_last (last), .i_special (special),
    .i_mul_op1 (mul_op1), .i_mul_op2 (mul_op2), .i_mul_sub (mul_sub),
    .i_mul_hi_nxt (mul_hi_nxt), .i_mul_lo_nxt (mul_lo_nxt),
    .i_mul_sft1_nxt (mul_sft1_nxt), .i_mul_res (mul_res),
    .i_div_op1 (div_op1), .i_div_op2 (div_op2), .i_div_sub (div_sub),
    .i_div_hi_ena (div_hi_ena), .i_div_hi_nxt (div_hi_nxt),
    .i_div_lo_ena (div_lo_ena), .i_div_lo_nxt (div_lo_nxt),
    .i_div_remd_sft1_nxt (div_remd_sft1_nxt), .i_div_res (div_res),
    .o_add_res (add_res), .o_part_hi (part_hi), .o_part_lo (part_lo),
    .o_part_sft1 (part_sft1), .o_remd_sft1 (remd_sft1), .o_data (o_data)
  );

endmodule

//--- bench/muldiv_vectors.svh
`ifndef MULDIV_VECTORS_SVH
`define MULDIV_VECTORS_SVH

// Each row gives name, operation, rs1, rs2 and cycles of sink back-pressure
// Expected values come from the reference model when the row is added
task automatic load_directed_rows();
  // Multiply, small and extreme operands
  add_row("mul small", OP_MUL, 32'd7, 32'd6, 0);
  add_row("mul negative", OP_MUL, -32'd3, 32'd5, 0);
  add_row("mul min by ones", OP_MUL, 32'h8000_0000, 32'hffff_ffff, 0);
  add_row("mul stalled", OP_MUL, 32'hdead_beef, 32'h0123_4567, 2);
  add_row("mulh min by min", OP_MULH, 32'h8000_0000, 32'h8000_0000, 0);
  add_row("mulh min by max", OP_MULH, 32'h8000_0000, 32'h7fff_ffff, 0);
  add_row("mulh ones", OP_MULH, 32'hffff_ffff, 32'hffff_ffff, 0);
  add_row("mulhsu ones", OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0);
  add_row("mulhsu max", OP_MULHSU, 32'h7fff_ffff, 32'hffff_ffff, 0);
  add_row("mulhsu min", OP_MULHSU, 32'h8000_0000, 32'h8000_0000, 0);
  add_row("mulhu max", OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 0);
  add_row("mulhu stalled", OP_MULHU, 32'h1234_5678, 32'h9abc_def0, 3);
  // Divide, signs mixed, exact multiples trigger corrections
  add_row("div pos", OP_DIV, 32'd100, 32'd7, 0);
  add_row("div neg dividend", OP_DIV, -32'd100, 32'd7, 0);
  add_row("div neg divisor", OP_DIV, 32'd100, -32'd7, 0);
  add_row("div both neg", OP_DIV, -32'd100, -32'd7, 0);
  add_row("div exact", OP_DIV, 32'd42, 32'd6, 0);
  add_row("div exact neg", OP_DIV, -32'd42, 32'd6, 1);
  add_row("divu big", OP_DIVU, 32'hffff_ffff, 32'd3, 0);
  add_row("divu small", OP_DIVU, 32'd5, 32'd10, 0);
  add_row("divu min by ones", OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 0);
  add_row("rem pos", OP_REM, 32'd100, 32'd7, 0);
  add_row("rem neg dividend", OP_REM, -32'd100, 32'd7, 0);
  add_row("rem exact neg", OP_REM, -32'd42, -32'd6, 3);
  add_row("remu big", OP_REMU, 32'hffff_ffff, 32'd10, 0);
  add_row("remu exact", OP_REMU, 32'd64, 32'd8, 0);
  // Fixed results, valid in the cycle the row appears
  add_row("div by zero", OP_DIV, 32'd1234, 32'd0, 0);
  add_row("divu by zero", OP_DIVU, 32'hffff_ffff, 32'd0, 0);
  add_row("rem by zero", OP_REM, -32'd5, 32'd0, 2);
  add_row("remu by zero", OP_REMU, 32'd1234, 32'd0, 0);
  add_row("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
  add_row("rem overflow", OP_REM, 32'h8000_0000, 32'hffff_ffff, 3);
endtask

`endif

//--- bench/muldiv_tb.sv
`timescale 1ns/1ps

module muldiv_tb
  import muldiv_pkg::*;
();

  logic            clk;
  logic            i_reset;
  logic            i_valid;
  logic            o_ready;
  logic [OP_W-1:0] i_op;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic            o_valid;
  logic            i_o_ready;
  logic [XLEN-1:0] o_data;

  // Row table, filled before reset ends
  string           row_name[$];
  logic [OP_W-1:0] row_op[$];
  logic [XLEN-1:0] row_rs1[$];
  logic [XLEN-1:0] row_rs2[$];
  logic [XLEN-1:0] row_exp[$];
  int              row_stall[$];

  int     num_rows = 0;
  int     tests = 0;
  int     checks = 0;
  int     errors = 0;
  integer seed;

  muldiv_top dut (
    .clk (clk), .i_reset (i_reset),
    .i_valid (i_valid), .o_ready (o_ready),
    .i_op (i_op), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
    .o_valid (o_valid), .i_o_ready (i_o_ready), .o_data (o_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model from the M-extension rules
  ////////////////////////////////////////////////////////////
  // Zero divisor, or most negative over minus one on signed forms
  function automatic bit divide_special(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    return op[2] && ((b == '0) || (!op[0] && a == 32'h8000_0000 && b == '1));
  endfunction

  function automatic logic [XLEN-1:0] riscv_m_result(input logic [OP_W-1:0] op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
    logic [63:0]     p_ss;
    logic [63:0]     p_su;
    logic [63:0]     p_uu;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quo_u;
    logic [XLEN-1:0] rem_u;
    int              qa;
    int              qb;
    // 64-bit wrap of the extended operands keeps the full product
    p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    p_su = {{32{a[31]}}, a} * {32'b0, b};
    p_uu = {32'b0, a} * {32'b0, b};
    qa = a;
    qb = b;
    if (b == '0) begin
      quo   = '1;
      rem   = a;
      quo_u = '1;
      rem_u = a;
    end else begin
      quo_u = a / b;
      rem_u = a % b;
      if (a == 32'h8000_0000 && b == '1) begin
        quo = 32'h8000_0000;
        rem = '0;
      end else begin
        // Signed int division truncates toward zero
        quo = qa / qb;
        rem = qa % qb;
      end
    end
    case (op)
      OP_MUL:    return p_uu[31:0];
      OP_MULH:   return p_ss[63:32];
      OP_MULHSU: return p_su[63:32];
      OP_MULHU:  return p_uu[63:32];
      OP_DIV:    return quo;
      OP_DIVU:   return quo_u;
      OP_REM:    return rem;
      default:   return rem_u;
    endcase
  endfunction

  task automatic add_row(input string name, input logic [OP_W-1:0] op,
                         input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input int stall);
    row_name.push_back(name);
    row_op.push_back(op);
    row_rs1.push_back(a);
    row_rs2.push_back(b);
    row_exp.push_back(riscv_m_result(op, a, b));
    row_stall.push_back(stall);
  endtask

  `include "muldiv_vectors.svh"

  task automatic add_random_rows(input int count);
    logic [OP_W-1:0] op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              pick;
    for (int n = 0; n < count; n++) begin
      op   = $random(seed);
      a    = $random(seed);
      b    = $random(seed);
      pick = $unsigned($random(seed)) % 8;
      // Bias toward zero divisors, small divisors and the most negative dividend
      if (pick == 0) begin
        b = '0;
      end else if (pick == 1) begin
        b = b & 32'hff;
      end else if (pick == 2) begin
        a = 32'h8000_0000;
      end
      add_row($sformatf("random %0d", n), op, a, b, (pick == 3) ? 2 : 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s expected 0x%h (%0d) actual 0x%h (%0d)", what, exp, exp, act, act);
    end
  endtask

  // Drive on the falling edge, sample 1 ns later once outputs settle
  task automatic run_row(input int idx);
    string           name;
    int              lat;
    int              exp_lat;
    int              err_before;
    logic [XLEN-1:0] got;
    name       = row_name[idx];
    err_before = errors;
    @(negedge clk);
    i_valid   = 1'b1;
    i_op      = row_op[idx];
    i_rs1     = row_rs1[idx];
    i_rs2     = row_rs2[idx];
    i_o_ready = (row_stall[idx] == 0);
    lat       = 0;
    #1;
    while (o_valid !== 1'b1) begin
      @(negedge clk);
      lat++;
      #1;
    end
    got = o_data;
    check_value({name, " data"}, row_exp[idx], got);
    // Multiply ends on count 16, divide on the check or the remainder fix-up
    if (!row_op[idx][2]) begin
      exp_lat = 16;
    end else if (divide_special(row_op[idx], row_rs1[idx], row_rs2[idx])) begin
      exp_lat = 0;
    end else begin
      exp_lat = (lat == 35) ? 35 : 33;
    end
    check_value({name, " latency"}, exp_lat, lat);
    // Sink stalls, result must hold
    for (int k = 0; k < row_stall[idx]; k++) begin
      check_value({name, " issue ready low"}, 1'b0, o_ready);
      @(negedge clk);
      if (k == row_stall[idx] - 1) begin
        i_o_ready = 1'b1;
      end
      #1;
      check_value({name, " valid held"}, 1'b1, o_valid);
      check_value({name, " data held"}, got, o_data);
    end
    check_value({name, " issue ready"}, 1'b1, o_ready);
    // Handshake completes on this rising edge
    @(negedge clk);
    i_valid = 1'b0;
    #1;
    check_value({name, " idle valid"}, 1'b0, o_valid);
    check_value({name, " idle ready"}, 1'b0, o_ready);
    tests++;
    if (errors == err_before) begin
      $display("test %s ok, latency %0d", name, lat);
    end else begin
      $display("test %s failed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    wait (num_rows > 0);
    repeat (num_rows * 40 + 100) @(posedge clk);
    $display("Timeout, the unit stopped answering before all rows were done");
    $display("Errors found");
    $finish;
  end

  initial begin
    seed      = 43;
    i_reset   = 1'b1;
    i_valid   = 1'b0;
    i_op      = '0;
    i_rs1     = '0;
    i_rs2     = '0;
    i_o_ready = 1'b0;
    load_directed_rows();
    add_random_rows(40);
    num_rows = row_op.size();
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    // Quiet outputs after reset with nothing presented
    for (int k = 0; k < 3; k++) begin
      #1;
      check_value("reset valid", 1'b0, o_valid);
      check_value("reset ready", 1'b0, o_ready);
      @(negedge clk);
    end
    tests++;
    $display("test reset done");
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+bench
design/muldiv_pkg.sv
design/muldiv_ctrl.sv
design/booth_mul_step.sv
design/nonrest_div_step.sv
design/muldiv_share.sv
design/muldiv_top.sv
bench/muldiv_tb.sv
